// File: source/raster_pkg.sv
package raster_pkg;

	localparam int block_bits = 2;                          // log2 of the block side.
	localparam int block_side = 1 << block_bits;
	localparam int block_pixels = block_side * block_side;  // one mask bit per pixel.

	// unsigned screen coordinate in whole pixels.
	typedef logic [9:0] coord;

	typedef struct packed {
		coord x;
		coord y;
	} raster_xy;

	// edge function value, wide enough for 10-bit products and their sums.
	typedef logic signed [31:0] edge_val;

	// one value per edge, edge k runs from vertex k to vertex k+1.
	typedef edge_val [2:0] edge_tri;

	// block count minus one along an axis.
	typedef logic [7:0] coarse_dim;

	// bit 4*row + column covers the pixel at that offset in the block.
	typedef logic [block_pixels - 1:0] cover_mask;

endpackage

// File: source/skid_flow.sv
`timescale 1ns/1ps

module skid_flow (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	output logic in_ready,
	input  logic out_ready,
	output logic out_valid,
	output logic stall,
	output logic load_main,
	output logic load_spare,
	output logic take_spare
);

	logic full, spare_full, accept;

	assign out_valid = full;
	assign in_ready = !spare_full;
	assign stall = spare_full;                // upstream must hold its word.
	assign accept = in_valid && in_ready;

	assign load_main = accept && (!full || out_ready);
	assign load_spare = accept && full && !out_ready;   // main is stuck, park the new word.
	assign take_spare = spare_full && out_ready;        // older word left, spare moves up.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
			spare_full <= 1'b0;
		end else begin
			if (load_main || take_spare)
				full <= 1'b1;
			else if (out_ready)
				full <= 1'b0;

			if (load_spare)
				spare_full <= 1'b1;
			else if (take_spare)
				spare_full <= 1'b0;
		end
	end

endmodule

// File: source/skid_buf.sv
`timescale 1ns/1ps

module skid_buf #(
	parameter int width = 8
) (
	input  logic               clk,
	input  logic [width - 1:0] in,
	output logic [width - 1:0] out,
	input  logic               load_main,
	input  logic               load_spare,
	input  logic               take_spare
);

	logic [width - 1:0] main_q, spare_q;

	assign out = main_q;

	always_ff @(posedge clk) begin
		if (load_main)
			main_q <= in;
		else if (take_spare)
			main_q <= spare_q;

		if (load_spare)
			spare_q <= in;
	end

endmodule

// File: source/tri_setup.sv
`timescale 1ns/1ps

module tri_setup (
	input  logic                  clk,
	input  logic                  rst_n,
	input  raster_pkg::coord      v0_x,
	input  raster_pkg::coord      v0_y,
	input  raster_pkg::coord      v1_x,
	input  raster_pkg::coord      v1_y,
	input  raster_pkg::coord      v2_x,
	input  raster_pkg::coord      v2_y,
	input  logic                  tri_valid,
	output logic                  tri_ready,
	output raster_pkg::raster_xy  pos_ref,
	output raster_pkg::coarse_dim span_x,
	output raster_pkg::coarse_dim span_y,
	output raster_pkg::edge_tri   edge_refs,
	output raster_pkg::edge_tri   step_x,
	output raster_pkg::edge_tri   step_y,
	output logic                  setup_valid,
	input  logic                  setup_ready
);

	raster_pkg::coord min_x, max_x, min_y, max_y, org_x, org_y;
	raster_pkg::coord vx [3];
	raster_pkg::coord vy [3];
	raster_pkg::edge_tri a_n, b_n, e_n;
	logic take;

	function automatic raster_pkg::coord min3(raster_pkg::coord a, raster_pkg::coord b,
		raster_pkg::coord c);
		raster_pkg::coord m;
		m = (a < b) ? a : b;
		return (c < m) ? c : m;
	endfunction

	function automatic raster_pkg::coord max3(raster_pkg::coord a, raster_pkg::coord b,
		raster_pkg::coord c);
		raster_pkg::coord m;
		m = (a > b) ? a : b;
		return (c > m) ? c : m;
	endfunction

	assign tri_ready = !setup_valid || setup_ready;
	assign take = tri_valid && tri_ready;

	assign vx = '{v0_x, v1_x, v2_x};
	assign vy = '{v0_y, v1_y, v2_y};

	assign min_x = min3(v0_x, v1_x, v2_x);
	assign max_x = max3(v0_x, v1_x, v2_x);
	assign min_y = min3(v0_y, v1_y, v2_y);
	assign max_y = max3(v0_y, v1_y, v2_y);

	assign org_x = min_x & ~raster_pkg::coord'(raster_pkg::block_side - 1);  // round down to grid.
	assign org_y = min_y & ~raster_pkg::coord'(raster_pkg::block_side - 1);

	// E = A*x + B*y + C, evaluated once at the box origin.
	always_comb begin
		raster_pkg::edge_val xa, ya, xb, yb, px, py;
		px = raster_pkg::edge_val'(org_x);
		py = raster_pkg::edge_val'(org_y);
		for (int k = 0; k < 3; k++) begin
			xa = raster_pkg::edge_val'(vx[k]);
			ya = raster_pkg::edge_val'(vy[k]);
			xb = raster_pkg::edge_val'(vx[(k + 1) % 3]);
			yb = raster_pkg::edge_val'(vy[(k + 1) % 3]);
			a_n[k] = ya - yb;
			b_n[k] = xb - xa;
			e_n[k] = a_n[k] * px + b_n[k] * py + xa * yb - xb * ya;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			setup_valid <= 1'b0;
		else if (tri_ready)
			setup_valid <= tri_valid;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pos_ref.x <= org_x;
			pos_ref.y <= org_y;
			span_x <= raster_pkg::coarse_dim'((max_x >> raster_pkg::block_bits) -
				(min_x >> raster_pkg::block_bits));
			span_y <= raster_pkg::coarse_dim'((max_y >> raster_pkg::block_bits) -
				(min_y >> raster_pkg::block_bits));
			edge_refs <= e_n;
			step_x <= a_n;
			step_y <= b_n;
		end
	end

	a_setup_hold: assert property (@(posedge clk) disable iff (!rst_n)
		setup_valid && !setup_ready |=> setup_valid && $stable(edge_refs));

endmodule

// File: source/coarse_raster.sv
`timescale 1ns/1ps

module coarse_raster (
	input  logic                  clk,
	input  logic                  rst_n,
	input  raster_pkg::raster_xy  pos_ref,
	input  raster_pkg::coarse_dim span_x,
	input  raster_pkg::coarse_dim span_y,
	input  raster_pkg::edge_tri   edge_refs,
	input  raster_pkg::edge_tri   step_x,
	input  raster_pkg::edge_tri   step_y,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic                  out_ready,
	output logic                  out_valid,
	output raster_pkg::raster_xy  pos,
	output raster_pkg::edge_tri   corners,
	output raster_pkg::edge_tri   pos_step_x,
	output raster_pkg::edge_tri   pos_step_y
);

	raster_pkg::coord ref_x;
	raster_pkg::raster_xy next_pos, send_pos;
	raster_pkg::coarse_dim stride_x, stride_y, width;
	raster_pkg::edge_tri edge_fns, edge_vert, edge_vert_next, edge_tests;
	raster_pkg::edge_tri tri_step_x, tri_step_y, x_offsets, y_offsets, test_offsets;
	raster_pkg::edge_tri send_corners, send_step_x, send_step_y;
	logic [2:0] edge_signs;
	logic running, send_valid, send, start, end_x, end_y;
	logic skid_ready, stall, load_main, load_spare, take_spare;
	logic [$bits(raster_pkg::raster_xy) + 3 * $bits(raster_pkg::edge_tri) - 1:0] blk_word,
		skid_word;

	assign end_x = stride_x == '0;
	assign end_y = stride_y == '0;

	assign send = &edge_signs && send_valid;
	assign in_ready = skid_ready && !running;
	assign start = in_valid && in_ready;

	assign blk_word = {send_pos, send_corners, send_step_x, send_step_y};
	assign {pos, corners, pos_step_x, pos_step_y} = skid_word;

	skid_flow skid_flow0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(send),
		.in_ready(skid_ready),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.stall(stall),
		.load_main(load_main),
		.load_spare(load_spare),
		.take_spare(take_spare)
	);

	skid_buf #(.width($bits(blk_word))) skid_buf0 (
		.clk(clk),
		.in(blk_word),
		.out(skid_word),
		.load_main(load_main),
		.load_spare(load_spare),
		.take_spare(take_spare)
	);

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			x_offsets[i] = tri_step_x[i] <<< raster_pkg::block_bits;
			y_offsets[i] = tri_step_y[i] <<< raster_pkg::block_bits;
			// push toward the corner where E is largest.
			test_offsets[i] = raster_pkg::edge_val'(raster_pkg::block_side - 1) *
				((tri_step_x[i][31] ? '0 : tri_step_x[i]) +
				(tri_step_y[i][31] ? '0 : tri_step_y[i]));
			edge_tests[i] = edge_fns[i] + test_offsets[i];
			edge_vert_next[i] = edge_vert[i] + y_offsets[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			send_valid <= 1'b0;
		end else if (!stall) begin
			if (running)
				running <= !end_x || !end_y;
			else
				running <= start;

			send_valid <= running;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			send_pos <= next_pos;
			send_corners <= edge_fns;
			send_step_x <= tri_step_x;
			send_step_y <= tri_step_y;

			stride_x <= stride_x - 1'b1;
			next_pos.x <= next_pos.x + raster_pkg::coord'(raster_pkg::block_side);

			for (int i = 0; i < 3; i++) begin
				edge_fns[i] <= edge_fns[i] + x_offsets[i];
				edge_signs[i] <= !edge_tests[i][$bits(raster_pkg::edge_val) - 1];
			end

			if (end_x) begin                 // row done, rewind x.
				next_pos.x <= ref_x;
				next_pos.y <= next_pos.y + raster_pkg::coord'(raster_pkg::block_side);
				stride_x <= width;
				stride_y <= stride_y - 1'b1;
				edge_fns <= edge_vert_next;
				edge_vert <= edge_vert_next;
			end

			if (start) begin
				next_pos <= pos_ref;
				ref_x <= pos_ref.x;
				width <= span_x;
				stride_x <= span_x;
				stride_y <= span_y;
				edge_fns <= edge_refs;
				edge_vert <= edge_refs;
				tri_step_x <= step_x;
				tri_step_y <= step_y;
			end
		end
	end

	// a new triangle always starts a walk that blocks the input.
	a_walk_busy: assert property (@(posedge clk) disable iff (!rst_n)
		start |=> running && !in_ready);

endmodule

// File: source/fine_raster.sv
`timescale 1ns/1ps

module fine_raster (
	input  logic                  clk,
	input  logic                  rst_n,
	input  raster_pkg::raster_xy  in_pos,
	input  raster_pkg::edge_tri   in_corners,
	input  raster_pkg::edge_tri   in_step_x,
	input  raster_pkg::edge_tri   in_step_y,
	input  logic                  in_valid,
	output logic                  in_ready,
	output raster_pkg::raster_xy  out_pos,
	output raster_pkg::cover_mask out_mask,
	output logic                  out_valid,
	input  logic                  out_ready
);

	raster_pkg::cover_mask mask;
	logic hit_any;

	assign in_ready = !out_valid || out_ready;
	assign hit_any = |mask;

	always_comb begin
		raster_pkg::edge_val e;
		logic hit;
		mask = '0;
		for (int r = 0; r < raster_pkg::block_side; r++) begin
			for (int c = 0; c < raster_pkg::block_side; c++) begin
				hit = 1'b1;
				for (int i = 0; i < 3; i++) begin
					e = in_corners[i] + c * in_step_x[i] + r * in_step_y[i];
					hit = hit && !e[$bits(raster_pkg::edge_val) - 1];  // on the edge counts.
				end
				mask[r * raster_pkg::block_side + c] = hit;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid && hit_any;   // empty blocks vanish here.
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready && hit_any) begin
			out_pos <= in_pos;
			out_mask <= mask;
		end
	end

	a_mask_live: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_mask != '0);

endmodule

// File: source/raster_top.sv
`timescale 1ns/1ps

module raster_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  raster_pkg::coord      v0_x,
	input  raster_pkg::coord      v0_y,
	input  raster_pkg::coord      v1_x,
	input  raster_pkg::coord      v1_y,
	input  raster_pkg::coord      v2_x,
	input  raster_pkg::coord      v2_y,
	input  logic                  tri_valid,
	output logic                  tri_ready,
	output raster_pkg::raster_xy  out_pos,
	output raster_pkg::cover_mask out_mask,
	output logic                  out_valid,
	input  logic                  out_ready
);

	raster_pkg::raster_xy pos_ref, blk_pos;
	raster_pkg::coarse_dim span_x, span_y;
	raster_pkg::edge_tri edge_refs, step_x, step_y;
	raster_pkg::edge_tri blk_corners, blk_step_x, blk_step_y;
	logic setup_valid, setup_ready, blk_valid, blk_ready;

	tri_setup setup0 (
		.clk(clk),
		.rst_n(rst_n),
		.v0_x(v0_x),
		.v0_y(v0_y),
		.v1_x(v1_x),
		.v1_y(v1_y),
		.v2_x(v2_x),
		.v2_y(v2_y),
		.tri_valid(tri_valid),
		.tri_ready(tri_ready),
		.pos_ref(pos_ref),
		.span_x(span_x),
		.span_y(span_y),
		.edge_refs(edge_refs),
		.step_x(step_x),
		.step_y(step_y),
		.setup_valid(setup_valid),
		.setup_ready(setup_ready)
	);

	coarse_raster coarse0 (
		.clk(clk),
		.rst_n(rst_n),
		.pos_ref(pos_ref),
		.span_x(span_x),
		.span_y(span_y),
		.edge_refs(edge_refs),
		.step_x(step_x),
		.step_y(step_y),
		.in_valid(setup_valid),
		.in_ready(setup_ready),
		.out_ready(blk_ready),
		.out_valid(blk_valid),
		.pos(blk_pos),
		.corners(blk_corners),
		.pos_step_x(blk_step_x),
		.pos_step_y(blk_step_y)
	);

	fine_raster fine0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_pos(blk_pos),
		.in_corners(blk_corners),
		.in_step_x(blk_step_x),
		.in_step_y(blk_step_y),
		.in_valid(blk_valid),
		.in_ready(blk_ready),
		.out_pos(out_pos),
		.out_mask(out_mask),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// File: testbench/raster_tb.sv
`timescale 1ns/1ps

module raster_tb;

	localparam int n_tri = 10;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	raster_pkg::coord v0_x = '0, v0_y = '0, v1_x = '0, v1_y = '0, v2_x = '0, v2_y = '0;
	logic tri_valid = 1'b0;
	logic tri_ready;
	raster_pkg::raster_xy out_pos;
	raster_pkg::cover_mask out_mask;
	logic out_valid;
	logic out_ready = 1'b1;

	logic bp_on = 1'b0;
	logic [31:0] lfsr = 32'h0b8bed27;
	logic [35:0] exp_q [$];                 // {x, y, mask} per expected block.
	int cycles = 0;
	int limit = 0;
	int value_errors = 0;
	int unexpected_errors = 0;
	int missing_errors = 0;
	int timeout_errors = 0;

	// v0_x, v0_y, v1_x, v1_y, v2_x, v2_y, back-pressure.
	int tri_tab [n_tri][7] = '{
		'{9, 9, 11, 9, 9, 11, 0},           // small, one block.
		'{2, 3, 45, 10, 12, 38, 0},         // spans many blocks.
		'{8, 4, 6, 20, 30, 14, 0},          // clockwise.
		'{1, 1, 13, 7, 7, 4, 0},            // collinear points cover only the line.
		'{20, 20, 40, 22, 25, 35, 0},
		'{9, 9, 11, 9, 9, 11, 1},
		'{2, 3, 45, 10, 12, 38, 1},
		'{8, 4, 6, 20, 30, 14, 1},
		'{1, 1, 13, 7, 7, 4, 1},
		'{20, 20, 40, 22, 25, 35, 1}
	};

	raster_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.v0_x(v0_x),
		.v0_y(v0_y),
		.v1_x(v1_x),
		.v1_y(v1_y),
		.v2_x(v2_x),
		.v2_y(v2_y),
		.tri_valid(tri_valid),
		.tri_ready(tri_ready),
		.out_pos(out_pos),
		.out_mask(out_mask),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32, 22, 2, 1.
	endfunction

	function automatic int edge_at(input int xa, input int ya, input int xb, input int yb,
		input int x, input int y);
		return (ya - yb) * x + (xb - xa) * y + (xa * yb - xb * ya);
	endfunction

	function automatic int box_blocks(input int t);
		int lo_x, hi_x, lo_y, hi_y;
		lo_x = tri_tab[t][0];
		hi_x = tri_tab[t][0];
		lo_y = tri_tab[t][1];
		hi_y = tri_tab[t][1];
		for (int k = 1; k < 3; k++) begin
			lo_x = (tri_tab[t][2 * k] < lo_x) ? tri_tab[t][2 * k] : lo_x;
			hi_x = (tri_tab[t][2 * k] > hi_x) ? tri_tab[t][2 * k] : hi_x;
			lo_y = (tri_tab[t][2 * k + 1] < lo_y) ? tri_tab[t][2 * k + 1] : lo_y;
			hi_y = (tri_tab[t][2 * k + 1] > hi_y) ? tri_tab[t][2 * k + 1] : hi_y;
		end
		return (hi_x / 4 - lo_x / 4 + 1) * (hi_y / 4 - lo_y / 4 + 1);
	endfunction

	// walk the aligned box in raster order and keep only the non-empty masks.
	task automatic add_expected(input int t);
		int vx [3];
		int vy [3];
		int lo_x, hi_x, lo_y, hi_y, px, py;
		logic [15:0] m;
		logic ok;
		for (int k = 0; k < 3; k++) begin
			vx[k] = tri_tab[t][2 * k];
			vy[k] = tri_tab[t][2 * k + 1];
		end
		lo_x = vx[0];
		hi_x = vx[0];
		lo_y = vy[0];
		hi_y = vy[0];
		for (int k = 1; k < 3; k++) begin
			lo_x = (vx[k] < lo_x) ? vx[k] : lo_x;
			hi_x = (vx[k] > hi_x) ? vx[k] : hi_x;
			lo_y = (vy[k] < lo_y) ? vy[k] : lo_y;
			hi_y = (vy[k] > hi_y) ? vy[k] : hi_y;
		end
		for (int by = lo_y / 4; by <= hi_y / 4; by++) begin
			for (int bx = lo_x / 4; bx <= hi_x / 4; bx++) begin
				m = '0;
				for (int r = 0; r < 4; r++) begin
					for (int c = 0; c < 4; c++) begin
						px = bx * 4 + c;
						py = by * 4 + r;
						ok = 1'b1;
						for (int k = 0; k < 3; k++) begin
							if (edge_at(vx[k], vy[k], vx[(k + 1) % 3], vy[(k + 1) % 3],
								px, py) < 0)
								ok = 1'b0;
						end
						m[r * 4 + c] = ok;
					end
				end
				if (m != '0)
					exp_q.push_back({10'(bx * 4), 10'(by * 4), m});
			end
		end
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got 'h%0h, expected 'h%0h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// hold the triangle with tri_valid high until the handshake edge.
	task automatic present(input int t);
		v0_x <= 10'(tri_tab[t][0]);
		v0_y <= 10'(tri_tab[t][1]);
		v1_x <= 10'(tri_tab[t][2]);
		v1_y <= 10'(tri_tab[t][3]);
		v2_x <= 10'(tri_tab[t][4]);
		v2_y <= 10'(tri_tab[t][5]);
		tri_valid <= 1'b1;
		bp_on <= tri_tab[t][6] != 0;
		do
			@(posedge clk);
		while (!tri_ready);
	endtask

	task automatic finish_run();
		if (exp_q.size() != 0) begin
			$display("%0d expected blocks never came out", exp_q.size());
			missing_errors += exp_q.size();
		end
		$display("value errors %0d, unexpected blocks %0d, missing blocks %0d, timeouts %0d",
			value_errors, unexpected_errors, missing_errors, timeout_errors);
		if (value_errors + unexpected_errors + missing_errors + timeout_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	always @(posedge clk) begin
		logic [31:0] s;
		if (bp_on) begin
			s = lfsr_next(lfsr);          // one step for the one bit taken.
			lfsr <= s;
			out_ready <= s[0];
		end else begin
			out_ready <= 1'b1;
		end
	end

	always @(posedge clk) begin
		logic [35:0] e;
		if (rst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("block at x %0d y %0d came out with no block expected",
					out_pos.x, out_pos.y);
				unexpected_errors++;
			end else begin
				e = exp_q.pop_front();
				check("out_pos.x", 32'(out_pos.x), 32'(e[35:26]));
				check("out_pos.y", 32'(out_pos.y), 32'(e[25:16]));
				check("out_mask", 32'(out_mask), 32'(e[15:0]));
			end
		end
	end

	initial begin
		while (cycles <= limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles with blocks still outstanding", cycles);
		timeout_errors++;
		finish_run();
	end

	initial begin
		for (int t = 0; t < n_tri; t++) begin
			add_expected(t);
			limit += 4 * box_blocks(t) + 40;
		end
		limit = 2 * limit;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check("tri_ready", 32'(tri_ready), 32'd1);
		check("out_valid", 32'(out_valid), 32'd0);

		for (int t = 0; t < n_tri; t++)
			present(t);
		tri_valid <= 1'b0;

		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (30) @(posedge clk);          // catch any stray blocks.
		finish_run();
	end

endmodule

// File: sources.f
source/raster_pkg.sv
source/skid_flow.sv
source/skid_buf.sv
source/tri_setup.sv
source/coarse_raster.sv
source/fine_raster.sv
source/raster_top.sv
testbench/raster_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the rasterizer testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module raster_tb \
	-f sources.f --Mdir obj_dir -o raster_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/raster_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
